// ==== src/cdc_cfg.svh ====
// request count, holdoff exponent width and synchronizer depth defines
`ifndef CDC_CFG_SVH
`define CDC_CFG_SVH

// asynchronous clock request inputs
// one synchronizer chain each
`define CDC_AREQ 4

// holdoff fields are exponents
// a value of n means 2**n clocks
`define CDC_HOLDOFF_W 4

// flops per asynchronous request chain
// two is the usual metastability margin
`define CDC_SYNC_STAGES 2

// the holdoff counter needs 2**CDC_HOLDOFF_W - 1 bits
// to hold the largest span minus one
// so 4 bits of exponent give a 15 bit counter

// all three are design-wide
// change CDC_AREQ here if a domain needs more request lines

`endif

// ==== src/cdc_pkg.sv ====
// ISM and gate state enums, wake request, configuration and status structs
`include "cdc_cfg.svh"

package cdc_pkg;

    // ISM state codes as driven by fabric and agent
    // only ISM_IDLE counts as quiet
    typedef enum logic [2:0] {
        ISM_IDLE       = 3'd0,
        ISM_IDLE_REQ   = 3'd1,
        ISM_ACTIVE_REQ = 3'd2,
        ISM_ACTIVE     = 3'd3,
        ISM_CREDIT_REQ = 3'd4
    } ism_state_e;

    // gating machine states
    typedef enum logic [2:0] {
        GATE_OFF     = 3'd0,
        GATE_REQ     = 3'd1,
        GATE_ACTIVE  = 3'd2,
        GATE_HOLDOFF = 3'd3,
        GATE_GATED   = 3'd4,
        GATE_RELEASE = 3'd5
    } gate_state_e;

    // every wake source of the domain
    typedef struct packed {
        logic                  gclock_req_sync;
        // asynchronous, synchronized inside the collector
        logic [`CDC_AREQ-1:0]  gclock_req_async;
        ism_state_e            ism_fabric;
        ism_state_e            ism_agent;
        logic                  force_clks_on;
    } cdc_req_t;

    // static configuration, held by software
    typedef struct packed {
        // never gate the clock on idle
        logic                       clkgate_disabled;
        // never drop clkreq on idle
        logic                       clkreq_ctl_disabled;
        // idle to gate, 2**n clocks
        logic [`CDC_HOLDOFF_W-1:0]  clkgate_holdoff;
        // gate to clkreq low, 2**n clocks
        logic [`CDC_HOLDOFF_W-1:0]  clkreq_off_holdoff;
    } cdc_cfg_t;

    // observation port
    typedef struct packed {
        gate_state_e  state;
        logic         wake;
    } cdc_status_t;

endpackage

// ==== src/cdc_request_collector.sv ====
// wake source collector with asynchronous request synchronizers and ISM decode
`timescale 1ns/10ps
`include "cdc_cfg.svh"

module cdc_request_collector (
    input  logic              clock,
    input  logic              reset,
    input  cdc_pkg::cdc_req_t req,
    output logic              wake
);

    // synchronizer chains, index 0 is the first flop
    // each stage holds one bit per asynchronous request
    logic [`CDC_SYNC_STAGES-1:0][`CDC_AREQ-1:0] sync_q;

    // synchronized asynchronous requests
    logic [`CDC_AREQ-1:0] async_req;

    // per source activity
    logic async_any;
    logic fabric_busy;
    logic agent_busy;
    logic sync_any;

    // shift the raw bits in at stage 0
    // they reach the last stage CDC_SYNC_STAGES edges later
    always_ff @(posedge clock) begin
        if (reset) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[`CDC_SYNC_STAGES-2:0], req.gclock_req_async};
        end
    end

    // last stage is the safe copy
    assign async_req = sync_q[`CDC_SYNC_STAGES-1];
    assign async_any = |async_req;

    // any ISM state but idle keeps the clock
    // credit and request states count as busy too
    assign fabric_busy = (req.ism_fabric != cdc_pkg::ISM_IDLE);
    assign agent_busy  = (req.ism_agent != cdc_pkg::ISM_IDLE);

    // synchronous sources go straight to wake
    // no delay on quiet detection
    assign sync_any = req.gclock_req_sync | req.force_clks_on;

    // one level for the gating machine
    // force counts as a wake source so the clock is kept running
    always_comb begin
        wake = 1'b0;
        if (sync_any) begin
            wake = 1'b1;
        end
        if (async_any) begin
            wake = 1'b1;
        end
        if (fabric_busy || agent_busy) begin
            wake = 1'b1;
        end
    end

    // ISM inputs are sampled in the domain clock already
    // only the asynchronous vector needs the chains above
    // a request pulse shorter than one clock may be missed
    // the request drivers hold their levels until the clock runs

endmodule

// ==== src/cdc_holdoff_timer.sv ====
// holdoff timer counting 2**exponent cycles with a sticky done flag
`timescale 1ns/10ps
`include "cdc_cfg.svh"

module cdc_holdoff_timer (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      start,
    input  logic                      clear,
    input  logic [`CDC_HOLDOFF_W-1:0] exponent,
    output logic                      done
);

    // wide enough for the largest span minus one
    localparam int CNT_W = (1 << `CDC_HOLDOFF_W) - 1;

    logic [CNT_W-1:0] count;
    logic             running;

    // load 2**exponent - 1, done lands 2**exponent edges after start
    // low exponent bits set, upper bits clear
    always_ff @(posedge clock) begin
        if (reset || clear) begin
            running <= 1'b0;
            done    <= 1'b0;
        end else if (start) begin
            running <= 1'b1;
            done    <= 1'b0;
        end else if (running && (count == '0)) begin
            // expiry, done holds until next start or clear
            running <= 1'b0;
            done    <= 1'b1;
        end
    end

    // count only moves while running
    always_ff @(posedge clock) begin
        if (start) begin
            count <= ~({CNT_W{1'b1}} << exponent);
        end else if (running && (count != '0)) begin
            count <= count - 1'b1;
        end
    end

endmodule

// ==== src/cdc_gate_fsm.sv ====
// clock gating FSM driving clkreq, clock enable, force ack and holdoff timer controls
`timescale 1ns/10ps

module cdc_gate_fsm (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 wake,
    input  logic                 clkack,
    input  logic                 gate_done,
    input  logic                 release_done,
    input  cdc_pkg::cdc_cfg_t    cfg,
    input  logic                 force_clks_on,
    output logic                 gate_start,
    output logic                 release_start,
    output logic                 timer_clear,
    output logic                 clkreq,
    output logic                 gclock_active,
    output logic                 force_clks_on_ack,
    output cdc_pkg::gate_state_e state
);

    cdc_pkg::gate_state_e next_state;

    // holdoff expiry qualified by the disable bits
    logic gate_ok;
    logic release_ok;

    assign gate_ok    = gate_done & ~cfg.clkgate_disabled;
    assign release_ok = release_done & ~cfg.clkreq_ctl_disabled;

    // next state
    always_comb begin
        next_state = state;
        case (state)
            cdc_pkg::GATE_OFF: begin
                // clkack must be low before a new request
                if (wake && !clkack) begin
                    next_state = cdc_pkg::GATE_REQ;
                end
            end
            cdc_pkg::GATE_REQ: begin
                if (clkack) begin
                    next_state = cdc_pkg::GATE_ACTIVE;
                end
            end
            cdc_pkg::GATE_ACTIVE: begin
                if (!wake) begin
                    next_state = cdc_pkg::GATE_HOLDOFF;
                end
            end
            cdc_pkg::GATE_HOLDOFF: begin
                // wake wins over a same cycle expiry
                if (wake) begin
                    next_state = cdc_pkg::GATE_ACTIVE;
                end else if (gate_ok) begin
                    next_state = cdc_pkg::GATE_GATED;
                end
            end
            cdc_pkg::GATE_GATED: begin
                // clkack still high here, clock comes back at once
                if (wake) begin
                    next_state = cdc_pkg::GATE_ACTIVE;
                end else if (release_ok) begin
                    next_state = cdc_pkg::GATE_RELEASE;
                end
            end
            cdc_pkg::GATE_RELEASE: begin
                // source must drop clkack before the next request
                if (!clkack) begin
                    next_state = cdc_pkg::GATE_OFF;
                end
            end
            default: begin
                next_state = cdc_pkg::GATE_OFF;
            end
        endcase
    end

    // timer controls, one cycle pulses on the transitions
    // gate timer starts on the first quiet cycle of ACTIVE
    assign gate_start = (state == cdc_pkg::GATE_ACTIVE) & ~wake;

    // release timer starts with the move into GATED
    assign release_start = (state == cdc_pkg::GATE_HOLDOFF) & ~wake & gate_ok;

    // wake during either holdoff abandons both counts
    assign timer_clear = wake & ((state == cdc_pkg::GATE_HOLDOFF) |
                                 (state == cdc_pkg::GATE_GATED));

    // state and registered outputs
    // outputs follow next_state so they change with the state
    always_ff @(posedge clock) begin
        if (reset) begin
            state             <= cdc_pkg::GATE_OFF;
            clkreq            <= 1'b0;
            gclock_active     <= 1'b0;
            force_clks_on_ack <= 1'b0;
        end else begin
            state <= next_state;
            // clkreq high from REQ through GATED
            clkreq <= (next_state == cdc_pkg::GATE_REQ) |
                      (next_state == cdc_pkg::GATE_ACTIVE) |
                      (next_state == cdc_pkg::GATE_HOLDOFF) |
                      (next_state == cdc_pkg::GATE_GATED);
            // clock enabled while acknowledged and not gated
            gclock_active <= (next_state == cdc_pkg::GATE_ACTIVE) |
                             (next_state == cdc_pkg::GATE_HOLDOFF);
            // force keeps wake high, so the clock stays on under it
            // ack drops one cycle after force does
            force_clks_on_ack <= force_clks_on & gclock_active;
        end
    end

endmodule

// ==== src/cdc_clock_gate_ctrl.sv ====
// clock gating controller top with collector, two holdoff timers and gate FSM
`timescale 1ns/10ps

module cdc_clock_gate_ctrl (
    input  logic                 clock,
    input  logic                 reset,
    input  cdc_pkg::cdc_req_t    req,
    input  cdc_pkg::cdc_cfg_t    cfg,
    input  logic                 clkack,
    output logic                 clkreq,
    output logic                 gclock_active,
    output logic                 force_clks_on_ack,
    output cdc_pkg::cdc_status_t status
);

    logic                 wake;
    logic                 gate_start;
    logic                 release_start;
    logic                 timer_clear;
    logic                 gate_done;
    logic                 release_done;
    cdc_pkg::gate_state_e state;

    // all wake sources down to one level
    cdc_request_collector collector_i (
        .clock (clock),
        .reset (reset),
        .req   (req),
        .wake  (wake)
    );

    // idle to clock gate holdoff
    cdc_holdoff_timer gate_timer_i (
        .clock    (clock),
        .reset    (reset),
        .start    (gate_start),
        .clear    (timer_clear),
        .exponent (cfg.clkgate_holdoff),
        .done     (gate_done)
    );

    // clock gate to clkreq low holdoff
    cdc_holdoff_timer release_timer_i (
        .clock    (clock),
        .reset    (reset),
        .start    (release_start),
        .clear    (timer_clear),
        .exponent (cfg.clkreq_off_holdoff),
        .done     (release_done)
    );

    cdc_gate_fsm fsm_i (
        .clock             (clock),
        .reset             (reset),
        .wake              (wake),
        .clkack            (clkack),
        .gate_done         (gate_done),
        .release_done      (release_done),
        .cfg               (cfg),
        .force_clks_on     (req.force_clks_on),
        .gate_start        (gate_start),
        .release_start     (release_start),
        .timer_clear       (timer_clear),
        .clkreq            (clkreq),
        .gclock_active     (gclock_active),
        .force_clks_on_ack (force_clks_on_ack),
        .state             (state)
    );

    // wake here is the combinational level, no extra delay
    assign status = '{state: state, wake: wake};

endmodule

// ==== testbench/cdc_asserts.sv ====
// bound assertion module checking the clock gating controller ports
`timescale 1ns/10ps

module cdc_asserts (
    input logic                 clock,
    input logic                 reset,
    input cdc_pkg::cdc_req_t    req,
    input cdc_pkg::cdc_cfg_t    cfg,
    input logic                 clkack,
    input logic                 clkreq,
    input logic                 gclock_active,
    input logic                 force_clks_on_ack,
    input cdc_pkg::cdc_status_t status
);

    // failed assertion count, watched by the testbench
    int fail_count = 0;

    // quiet cycles with the clock enabled
    int quiet_run = 0;
    // quiet cycles with the clock gated and clkreq still high
    int gated_run = 0;
    // cycles a wake has waited for the clock
    int wake_wait = 0;

    // counted mid cycle where every port is settled
    always @(negedge clock) begin
        if (reset || status.wake || !gclock_active) begin
            quiet_run <= 0;
        end else begin
            quiet_run <= quiet_run + 1;
        end
        if (reset || status.wake || gclock_active || !clkreq) begin
            gated_run <= 0;
        end else begin
            gated_run <= gated_run + 1;
        end
        if (reset || gclock_active) begin
            wake_wait <= 0;
        end else if (status.wake || wake_wait != 0) begin
            wake_wait <= wake_wait + 1;
        end
    end

    // outputs quiet and state OFF out of reset
    assert property (@(posedge clock) $past(reset) |-> !clkreq && !gclock_active
                     && !force_clks_on_ack && status.state == cdc_pkg::GATE_OFF)
        else begin
            fail_count = fail_count + 1;
            $error("error %0t: outputs not low after reset", $time);
        end

    // enabled clock needs a granted request
    assert property (@(posedge clock) disable iff (reset) gclock_active |-> clkack && clkreq)
        else begin
            fail_count = fail_count + 1;
            $error("error %0t: gclock_active high without clkreq and clkack", $time);
        end

    // a new request only once the old ack is gone
    assert property (@(posedge clock) disable iff (reset) $rose(clkreq) |-> !$past(clkack))
        else begin
            fail_count = fail_count + 1;
            $error("error %0t: clkreq rose while clkack was high", $time);
        end

    // a request follows a wake one cycle later
    assert property (@(posedge clock) disable iff (reset) $rose(clkreq) |-> $past(status.wake))
        else begin
            fail_count = fail_count + 1;
            $error("error %0t: clkreq rose without a wake", $time);
        end

    // reported state agrees with the output levels
    assert property (@(posedge clock) disable iff (reset)
                     gclock_active == (status.state inside {cdc_pkg::GATE_ACTIVE,
                                                            cdc_pkg::GATE_HOLDOFF}) &&
                     clkreq == (status.state inside {cdc_pkg::GATE_REQ, cdc_pkg::GATE_ACTIVE,
                                                     cdc_pkg::GATE_HOLDOFF,
                                                     cdc_pkg::GATE_GATED}))
        else begin
            fail_count = fail_count + 1;
            $error("error %0t: state %0d does not match clkreq and gclock_active", $time,
                   status.state);
        end

    // wake reaches the clock within the ack delay budget
    assert property (@(posedge clock) disable iff (reset) wake_wait <= 20)
        else begin
            fail_count = fail_count + 1;
            $error("error %0t: wake did not enable the clock", $time);
        end

    // idle holdoff plus the ACTIVE and HOLDOFF exit cycles
    assert property (@(posedge clock) disable iff (reset) $fell(gclock_active) |->
                     !cfg.clkgate_disabled &&
                     $past(quiet_run) == (1 << cfg.clkgate_holdoff) + 2)
        else begin
            fail_count = fail_count + 1;
            $error("error %0t: clock gated after %0d quiet cycles", $time, $past(quiet_run));
        end

    // clkreq release holdoff plus the GATED exit cycle
    assert property (@(posedge clock) disable iff (reset) $fell(clkreq) |->
                     !cfg.clkreq_ctl_disabled &&
                     $past(gated_run) == (1 << cfg.clkreq_off_holdoff) + 1)
        else begin
            fail_count = fail_count + 1;
            $error("error %0t: clkreq fell after %0d gated cycles", $time, $past(gated_run));
        end

    // force ack follows force one cycle late
    assert property (@(posedge clock) disable iff (reset)
                     req.force_clks_on && gclock_active |=> force_clks_on_ack)
        else begin
            fail_count = fail_count + 1;
            $error("error %0t: force_clks_on_ack did not rise", $time);
        end

    assert property (@(posedge clock) disable iff (reset)
                     !req.force_clks_on |=> !force_clks_on_ack)
        else begin
            fail_count = fail_count + 1;
            $error("error %0t: force_clks_on_ack did not fall", $time);
        end

endmodule

bind cdc_clock_gate_ctrl cdc_asserts asserts_i (
    .clock             (clock),
    .reset             (reset),
    .req               (req),
    .cfg               (cfg),
    .clkack            (clkack),
    .clkreq            (clkreq),
    .gclock_active     (gclock_active),
    .force_clks_on_ack (force_clks_on_ack),
    .status            (status)
);

// ==== testbench/cdc_tb.sv ====
// testbench with clock source model, xorshift stimulus and timeouts
`timescale 1ns/10ps
`include "cdc_cfg.svh"

module cdc_tb;

    localparam int SEL_CLKREQ = 0;
    localparam int SEL_ACTIVE = 1;
    localparam int SEL_ACK    = 2;

    logic                 clock = 1'b0;
    logic                 reset = 1'b1;
    cdc_pkg::cdc_req_t    req = '0;
    cdc_pkg::cdc_cfg_t    cfg = '0;
    logic                 clkack = 1'b0;
    logic                 clkreq;
    logic                 gclock_active;
    logic                 force_clks_on_ack;
    cdc_pkg::cdc_status_t status;

    logic [31:0] stim_rng = 32'hb913564f;
    logic [31:0] ack_rng = 32'hb913564f;
    int          ack_cnt = 1;

    cdc_clock_gate_ctrl dut_i (
        .clock             (clock),
        .reset             (reset),
        .req               (req),
        .cfg               (cfg),
        .clkack            (clkack),
        .clkreq            (clkreq),
        .gclock_active     (gclock_active),
        .force_clks_on_ack (force_clks_on_ack),
        .status            (status)
    );

    always #50 clock = ~clock;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int rand_below(input int n);
        stim_rng = xorshift(stim_rng);
        return int'(stim_rng % n);
    endfunction

    // clock source, follows clkreq after 1 to 4 cycles
    always @(posedge clock) begin
        #1;
        if (reset) begin
            clkack = 1'b0;
        end else if (clkreq == clkack) begin
            ack_rng = xorshift(ack_rng);
            ack_cnt = 1 + int'(ack_rng % 4);
        end else if (ack_cnt <= 1) begin
            clkack = clkreq;
        end else begin
            ack_cnt = ack_cnt - 1;
        end
    end

    // any failed assertion ends the run
    always @(negedge clock) begin
        if (dut_i.asserts_i.fail_count != 0) begin
            $display("CHECKS FAILED");
            $fatal(1, "assertion failure in the bound checker");
        end
    end

    task automatic tick();
        @(posedge clock);
        #1;
    endtask

    task automatic wait_output(input int sel, input logic level, input int limit);
        logic value;
        for (int n = 0; n < limit; n++) begin
            case (sel)
                SEL_CLKREQ: value = clkreq;
                SEL_ACTIVE: value = gclock_active;
                default:    value = force_clks_on_ack;
            endcase
            if (value == level) begin
                return;
            end
            tick();
        end
        $display("timed out at %0t waiting for output %0d to reach %0b", $time, sel, level);
        $display("CHECKS FAILED");
        $fatal(1, "wait timeout");
    endtask

    // back to OFF, both holdoffs allowed for
    task automatic settle();
        wait_output(SEL_CLKREQ, 1'b0, 80);
        repeat (6) tick();
    endtask

    task automatic new_cfg();
        settle();
        cfg.clkgate_holdoff    = 4'(rand_below(4));
        cfg.clkreq_off_holdoff = 4'(rand_below(4));
        tick();
    endtask

    // hold a wake source until the clock runs
    task automatic run_request(input cdc_pkg::cdc_req_t r, input bit to_idle);
        req = r;
        wait_output(SEL_ACTIVE, 1'b1, 40);
        repeat (rand_below(6)) tick();
        req = '0;
        if (to_idle) begin
            settle();
        end else begin
            repeat (rand_below(14)) tick();
        end
    endtask

    task automatic run_phase(input int kind);
        cdc_pkg::cdc_req_t r;
        for (int i = 0; i < 6; i++) begin
            if (i % 3 == 0) begin
                new_cfg();
            end
            r = '0;
            case (kind)
                0: r.gclock_req_sync = 1'b1;
                1: r.gclock_req_async = {{(`CDC_AREQ-1){1'b0}}, 1'b1} << rand_below(`CDC_AREQ);
                default: begin
                    // one ISM busy at a time
                    // each decode has to wake the domain alone
                    if ((i / 2) % 2 == 0) begin
                        r.ism_fabric = cdc_pkg::ism_state_e'(3'(1 + rand_below(4)));
                    end else begin
                        r.ism_agent  = cdc_pkg::ism_state_e'(3'(1 + rand_below(4)));
                    end
                end
            endcase
            run_request(r, (i % 2) == 1);
        end
    endtask

    initial begin
        cdc_pkg::cdc_req_t r;
        repeat (16) @(posedge clock);
        #1;
        reset = 1'b0;
        // quiet domain stays off
        repeat (20) tick();
        run_phase(0);
        run_phase(1);
        run_phase(2);

        // force clocks on
        for (int i = 0; i < 4; i++) begin
            new_cfg();
            r = '0;
            r.force_clks_on = 1'b1;
            req = r;
            wait_output(SEL_ACTIVE, 1'b1, 40);
            wait_output(SEL_ACK, 1'b1, 10);
            repeat (rand_below(8)) tick();
            req = '0;
            wait_output(SEL_ACK, 1'b0, 10);
        end

        // clock gate disabled, idle holds the clock
        new_cfg();
        cfg.clkgate_disabled = 1'b1;
        r = '0;
        r.gclock_req_sync = 1'b1;
        run_request(r, 1'b0);
        repeat ((1 << cfg.clkgate_holdoff) + 12) tick();
        req = r;
        cfg.clkgate_disabled = 1'b0;
        tick();
        req = '0;

        // clkreq control disabled, gated clock keeps clkreq
        new_cfg();
        cfg.clkreq_ctl_disabled = 1'b1;
        run_request(r, 1'b0);
        wait_output(SEL_ACTIVE, 1'b0, 40);
        repeat ((1 << cfg.clkreq_off_holdoff) + 12) tick();
        req = r;
        cfg.clkreq_ctl_disabled = 1'b0;
        wait_output(SEL_ACTIVE, 1'b1, 10);
        req = '0;
        settle();

        repeat (4) tick();
        if (dut_i.asserts_i.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("CHECKS FAILED");
            $fatal(1, "assertion failures at end of run");
        end
    end

endmodule

// ==== all.f ====
+incdir+src
src/cdc_pkg.sv
src/cdc_request_collector.sv
src/cdc_holdoff_timer.sv
src/cdc_gate_fsm.sv
src/cdc_clock_gate_ctrl.sv
testbench/cdc_asserts.sv
testbench/cdc_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the clock gating controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module cdc_tb -o cdc_sim \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/cdc_sim +verilator+error+limit+1000 > sim.log 2>&1

grep -q "CHECKS FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }

grep -q "ALL CHECKS PASSED" sim.log && { echo "simulation passed"; exit 0; } || \
    { echo "simulation ended without a result, see sim.log"; exit 1; }
